/* hdl/vga_dbuf_defines.svh */
`ifndef VGA_DBUF_DEFINES_SVH
`define VGA_DBUF_DEFINES_SVH

// visible area
`define VGA_H_ACTIVE 16
`define VGA_V_ACTIVE 8

// full raster including blanking
`define VGA_H_TOTAL 24
`define VGA_V_TOTAL 12

// sync pulses, active low
`define VGA_HS_START 18
`define VGA_HS_LEN 3
`define VGA_VS_START 9
`define VGA_VS_LEN 2

`define BANK_DEPTH 128

`endif

/* hdl/vga_dbuf_pkg.sv */
package vga_dbuf_pkg;

  // red in [11:8], green in [7:4], blue in [3:0]
  typedef logic [11:0] pixel_t;

  typedef logic [4:0] hpos_t;
  typedef logic [3:0] vpos_t;

  // y * 16 + x
  typedef logic [6:0] pix_addr_t;

  typedef logic [3:0] frame_tag_t;

  typedef enum logic [1:0] {
    IDLE,
    FILL,
    READY
  } swap_state_t;

endpackage

/* hdl/bank_port_if.sv */
`timescale 1ns/100ps

interface bank_port_if;

  logic                    en;
  logic                    we;
  vga_dbuf_pkg::pix_addr_t addr;
  vga_dbuf_pkg::pixel_t    wdata;
  // valid the cycle after a read strobe
  vga_dbuf_pkg::pixel_t    rdata;

  modport master (
    output en,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport bank (
    input  en,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

/* hdl/buf_swap_ctrl.sv */
`timescale 1ns/100ps

module buf_swap_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     enable,
  input  logic                     fill_done,
  input  logic                     frame_end,
  output logic                     fill_start,
  output vga_dbuf_pkg::frame_tag_t fill_tag,
  output logic                     front_sel,
  output logic                     shown_valid
);

  vga_dbuf_pkg::swap_state_t state;
  vga_dbuf_pkg::frame_tag_t  tag_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= vga_dbuf_pkg::IDLE;
      tag_next    <= '0;
      fill_tag    <= '0;
      fill_start  <= 1'b0;
      front_sel   <= 1'b0;
      shown_valid <= 1'b0;
    end else begin
      fill_start <= 1'b0;
      case (state)
        vga_dbuf_pkg::IDLE: begin
          if (enable) begin
            fill_start <= 1'b1;
            fill_tag   <= tag_next;
            tag_next   <= tag_next + 4'd1;
            state      <= vga_dbuf_pkg::FILL;
          end
        end
        vga_dbuf_pkg::FILL: begin
          if (fill_done) begin
            state <= vga_dbuf_pkg::READY;
          end
        end
        vga_dbuf_pkg::READY: begin
          // swap only in vertical blanking, back bank is complete
          if (frame_end) begin
            front_sel   <= ~front_sel;
            shown_valid <= 1'b1;
            state       <= vga_dbuf_pkg::IDLE;
          end
        end
        default: begin
          state <= vga_dbuf_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

/* hdl/pattern_writer.sv */
`timescale 1ns/100ps
`include "vga_dbuf_defines.svh"

module pattern_writer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     fill_start,
  input  vga_dbuf_pkg::frame_tag_t fill_tag,
  output logic                     fill_done,
  bank_port_if.master              wr
);

  localparam vga_dbuf_pkg::pix_addr_t LAST_ADDR = vga_dbuf_pkg::pix_addr_t'(`BANK_DEPTH - 1);

  logic                     busy;
  vga_dbuf_pkg::pix_addr_t  addr_cnt;
  vga_dbuf_pkg::frame_tag_t tag_q;
  logic [3:0]               pos_x;
  logic [3:0]               pos_y;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      addr_cnt  <= '0;
      fill_done <= 1'b0;
    end else begin
      // one cycle after the last write
      fill_done <= busy && (addr_cnt == LAST_ADDR);
      if (fill_start) begin
        busy     <= 1'b1;
        addr_cnt <= '0;
      end else if (busy) begin
        addr_cnt <= addr_cnt + 7'd1;
        if (addr_cnt == LAST_ADDR) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start) begin
      tag_q <= fill_tag;
    end
  end

  assign pos_x = 4'(addr_cnt % `VGA_H_ACTIVE);
  assign pos_y = 4'(addr_cnt / `VGA_H_ACTIVE);

  assign wr.en    = busy;
  assign wr.we    = busy;
  assign wr.addr  = addr_cnt;
  assign wr.wdata = {pos_x, pos_y, tag_q};

endmodule

/* hdl/frame_bank.sv */
`timescale 1ns/100ps
`include "vga_dbuf_defines.svh"

module frame_bank (
  input logic       clk,
  bank_port_if.bank port
);

  vga_dbuf_pkg::pixel_t mem [0:`BANK_DEPTH-1];
  vga_dbuf_pkg::pixel_t rdata_q;

  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.we) begin
        mem[port.addr] <= port.wdata;
      end else begin
        rdata_q <= mem[port.addr];
      end
    end
  end

  // holds the last read while idle
  assign port.rdata = rdata_q;

endmodule

/* hdl/bank_router.sv */
`timescale 1ns/100ps

module bank_router (
  input  logic        clk,
  input  logic        reset,
  input  logic        front_sel,
  bank_port_if.bank   wr,
  bank_port_if.bank   rd,
  bank_port_if.master bank0,
  bank_port_if.master bank1
);

  // select as seen by the data returning this cycle
  logic sel_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      sel_q <= 1'b0;
    end else begin
      sel_q <= front_sel;
    end
  end

  // front_sel = 0 shows bank0, writer goes to bank1
  assign bank0.en    = front_sel ? wr.en    : rd.en;
  assign bank0.we    = front_sel ? wr.we    : rd.we;
  assign bank0.addr  = front_sel ? wr.addr  : rd.addr;
  assign bank0.wdata = front_sel ? wr.wdata : rd.wdata;

  assign bank1.en    = front_sel ? rd.en    : wr.en;
  assign bank1.we    = front_sel ? rd.we    : wr.we;
  assign bank1.addr  = front_sel ? rd.addr  : wr.addr;
  assign bank1.wdata = front_sel ? rd.wdata : wr.wdata;

  assign rd.rdata = sel_q ? bank1.rdata : bank0.rdata;
  assign wr.rdata = sel_q ? bank0.rdata : bank1.rdata;

endmodule

/* hdl/scan_out.sv */
`timescale 1ns/100ps
`include "vga_dbuf_defines.svh"

module scan_out (
  input  logic        clk,
  input  logic        reset,
  input  logic        shown_valid,
  bank_port_if.master rd,
  output logic        frame_end,
  output logic [3:0]  vga_red,
  output logic [3:0]  vga_green,
  output logic [3:0]  vga_blue,
  output logic        vga_hsync,
  output logic        vga_vsync,
  output logic        vga_de
);

  localparam vga_dbuf_pkg::hpos_t H_LAST   = vga_dbuf_pkg::hpos_t'(`VGA_H_TOTAL - 1);
  localparam vga_dbuf_pkg::hpos_t H_VIS    = vga_dbuf_pkg::hpos_t'(`VGA_H_ACTIVE);
  localparam vga_dbuf_pkg::hpos_t HS_BEG   = vga_dbuf_pkg::hpos_t'(`VGA_HS_START);
  localparam vga_dbuf_pkg::hpos_t HS_END   = vga_dbuf_pkg::hpos_t'(`VGA_HS_START + `VGA_HS_LEN);
  localparam vga_dbuf_pkg::vpos_t V_LAST   = vga_dbuf_pkg::vpos_t'(`VGA_V_TOTAL - 1);
  localparam vga_dbuf_pkg::vpos_t V_VIS    = vga_dbuf_pkg::vpos_t'(`VGA_V_ACTIVE);
  localparam vga_dbuf_pkg::vpos_t V_LAST_V = vga_dbuf_pkg::vpos_t'(`VGA_V_ACTIVE - 1);
  localparam vga_dbuf_pkg::vpos_t VS_BEG   = vga_dbuf_pkg::vpos_t'(`VGA_VS_START);
  localparam vga_dbuf_pkg::vpos_t VS_END   = vga_dbuf_pkg::vpos_t'(`VGA_VS_START + `VGA_VS_LEN);

  vga_dbuf_pkg::hpos_t  hcnt;
  vga_dbuf_pkg::vpos_t  vcnt;
  vga_dbuf_pkg::pixel_t colour_q;
  logic                 visible;
  logic                 vis_d;
  logic                 hs_d;
  logic                 vs_d;

  // start at the last blanking position so nothing is read out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      hcnt      <= H_LAST;
      vcnt      <= V_LAST;
      frame_end <= 1'b0;
    end else begin
      frame_end <= (hcnt == H_LAST) && (vcnt == V_LAST_V);
      if (hcnt == H_LAST) begin
        hcnt <= '0;
        vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 4'd1;
      end else begin
        hcnt <= hcnt + 5'd1;
      end
    end
  end

  assign visible = (hcnt < H_VIS) && (vcnt < V_VIS);

  // stage 0: read request
  assign rd.en    = visible;
  assign rd.we    = 1'b0;
  assign rd.addr  = vga_dbuf_pkg::pix_addr_t'(vcnt * `VGA_H_ACTIVE + hcnt);
  assign rd.wdata = '0;

  // stage 1 delays timing to match the bank, stage 2 drives the pins
  always_ff @(posedge clk) begin
    if (reset) begin
      vis_d     <= 1'b0;
      hs_d      <= 1'b1;
      vs_d      <= 1'b1;
      vga_de    <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      colour_q  <= '0;
    end else begin
      vis_d     <= visible;
      hs_d      <= ~((hcnt >= HS_BEG) && (hcnt < HS_END));
      vs_d      <= ~((vcnt >= VS_BEG) && (vcnt < VS_END));
      vga_de    <= vis_d;
      vga_hsync <= hs_d;
      vga_vsync <= vs_d;
      colour_q  <= (vis_d && shown_valid) ? rd.rdata : '0;
    end
  end

  assign vga_red   = colour_q[11:8];
  assign vga_green = colour_q[7:4];
  assign vga_blue  = colour_q[3:0];

endmodule

/* hdl/vga_dbuf_top.sv */
`timescale 1ns/100ps

module vga_dbuf_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  output logic [3:0] vga_red,
  output logic [3:0] vga_green,
  output logic [3:0] vga_blue,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic       vga_de
);

  logic                     fill_start;
  logic                     fill_done;
  logic                     frame_end;
  logic                     front_sel;
  logic                     shown_valid;
  vga_dbuf_pkg::frame_tag_t fill_tag;

  bank_port_if wr_port ();
  bank_port_if rd_port ();
  bank_port_if bank0_port ();
  bank_port_if bank1_port ();

  buf_swap_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .fill_done  (fill_done),
    .frame_end  (frame_end),
    .fill_start (fill_start),
    .fill_tag   (fill_tag),
    .front_sel  (front_sel),
    .shown_valid(shown_valid)
  );

  pattern_writer u_writer (
    .clk       (clk),
    .reset     (reset),
    .fill_start(fill_start),
    .fill_tag  (fill_tag),
    .fill_done (fill_done),
    .wr        (wr_port.master)
  );

  bank_router u_router (
    .clk      (clk),
    .reset    (reset),
    .front_sel(front_sel),
    .wr       (wr_port.bank),
    .rd       (rd_port.bank),
    .bank0    (bank0_port.master),
    .bank1    (bank1_port.master)
  );

  frame_bank u_bank0 (
    .clk (clk),
    .port(bank0_port.bank)
  );

  frame_bank u_bank1 (
    .clk (clk),
    .port(bank1_port.bank)
  );

  scan_out u_scan (
    .clk        (clk),
    .reset      (reset),
    .shown_valid(shown_valid),
    .rd         (rd_port.master),
    .frame_end  (frame_end),
    .vga_red    (vga_red),
    .vga_green  (vga_green),
    .vga_blue   (vga_blue),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .vga_de     (vga_de)
  );

endmodule

/* tests/vga_dbuf_chk.sv */
`timescale 1ns/100ps

module vga_dbuf_chk (
  input logic clk,
  input logic reset,
  input logic frame_end,
  input logic front_sel,
  input logic wr_en,
  input logic rd_en,
  input logic bank0_en,
  input logic bank1_en
);

  int fail_count = 0;

  // bank select moves only in the cycle after frame_end
  a_swap_on_frame_end: assert property (@(posedge clk) disable iff (reset)
    (front_sel != $past(front_sel)) |-> $past(frame_end))
  else begin
    fail_count++;
    $error("front_sel changed without a frame_end pulse");
  end

  a_swap_outside_fill: assert property (@(posedge clk) disable iff (reset)
    (front_sel != $past(front_sel)) |-> !wr_en)
  else begin
    fail_count++;
    $error("banks swapped while the writer was still filling");
  end

  // both masters busy means they landed on different banks
  a_banks_apart: assert property (@(posedge clk) disable iff (reset)
    (wr_en && rd_en) |-> (bank0_en && bank1_en))
  else begin
    fail_count++;
    $error("writer and reader targeted the same bank");
  end

endmodule

/* tests/pixel_monitor.sv */
`timescale 1ns/100ps
`include "vga_dbuf_defines.svh"

module pixel_monitor (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  input  logic [3:0] vga_red,
  input  logic [3:0] vga_green,
  input  logic [3:0] vga_blue,
  input  logic       vga_hsync,
  input  logic       vga_vsync,
  input  logic       vga_de,
  output int         error_count,
  output int         check_count,
  output int         valid_frames
);

  int         cyc;
  int         last_hs_fall;
  int         hs_low_len;
  int         de_len;
  int         x;
  int         y;
  int         high_run;
  int         low_run;
  logic       en_seen;
  logic       seen_valid;
  logic       frame_valid;
  logic [3:0] frame_blue;
  logic [3:0] prev_blue;
  logic       hs_q;
  logic       vs_q;
  logic       de_q;

  // expected colour of pixel (px, py) in a frame written with tag
  function automatic logic [11:0] ref_pixel(input int px, input int py, input logic [3:0] tag);
    logic [3:0] r;
    logic [3:0] g;
    r = 4'(px % 16);
    g = 4'(py % 8);
    return {r, g, tag};
  endfunction

  task automatic compare(input string name, input int got, input int exp);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("ERROR %0t %s expected %0d got %0d (x=%0d y=%0d)", $time, name, exp, got, x, y);
    end
  endtask

  task automatic start_frame();
    logic [3:0] next_blue;
    if (en_seen) begin
      high_run++;
      low_run = 0;
    end else begin
      low_run++;
      high_run = 0;
    end
    en_seen     = 1'b0;
    frame_valid = seen_valid;
    prev_blue   = frame_blue;
    next_blue   = prev_blue + 4'd1;
    if (!seen_valid) begin
      // nothing shown yet, first shown frame carries tag 0
      frame_blue = 4'd0;
    end else begin
      if (low_run >= 2) begin
        compare("vga_blue held", int'(vga_blue), int'(prev_blue));
      end else if (high_run >= 3) begin
        compare("vga_blue step", int'(vga_blue), int'(next_blue));
      end else if (vga_blue != prev_blue) begin
        compare("vga_blue step", int'(vga_blue), int'(next_blue));
      end
      frame_blue = vga_blue;
    end
  endtask

  task automatic check_pixel();
    logic [11:0] exp;
    if (x == 0 && y == 0) begin
      start_frame();
    end
    if (x == 1 && y == 0) begin
      if (!seen_valid && vga_red != 4'd0) begin
        seen_valid  = 1'b1;
        frame_valid = 1'b1;
      end
      if (frame_valid) begin
        valid_frames++;
      end
    end
    exp = frame_valid ? ref_pixel(x, y, frame_blue) : 12'd0;
    compare("vga_red", int'(vga_red), int'(exp[11:8]));
    compare("vga_green", int'(vga_green), int'(exp[7:4]));
    compare("vga_blue", int'(vga_blue), int'(exp[3:0]));
  endtask

  always @(negedge clk) begin
    if (reset) begin
      error_count  = 0;
      check_count  = 0;
      valid_frames = 0;
      cyc          = 0;
      last_hs_fall = -1;
      hs_low_len   = 0;
      de_len       = 0;
      x            = 0;
      y            = 0;
      high_run     = 0;
      low_run      = 0;
      en_seen      = 1'b0;
      seen_valid   = 1'b0;
      frame_valid  = 1'b0;
      frame_blue   = 4'd0;
      prev_blue    = 4'd0;
      hs_q         = 1'b1;
      vs_q         = 1'b1;
      de_q         = 1'b0;
    end else begin
      cyc++;
      if (vga_de) begin
        check_pixel();
        x++;
        de_len++;
      end else if (de_q) begin
        compare("vga_de cycles per line", de_len, `VGA_H_ACTIVE);
        de_len = 0;
        y++;
      end
      if (!vga_hsync) begin
        hs_low_len++;
        x = 0;
        if (hs_q) begin
          if (last_hs_fall >= 0) begin
            compare("vga_hsync period", cyc - last_hs_fall, `VGA_H_TOTAL);
          end
          last_hs_fall = cyc;
        end
      end else if (!hs_q) begin
        compare("vga_hsync low cycles", hs_low_len, `VGA_HS_LEN);
        hs_low_len = 0;
      end
      if (!vga_vsync) begin
        if (vs_q) begin
          compare("vga_de lines per frame", y, `VGA_V_ACTIVE);
        end
        y = 0;
      end
      en_seen = en_seen | enable;
      hs_q    = vga_hsync;
      vs_q    = vga_vsync;
      de_q    = vga_de;
    end
  end

endmodule

/* tests/vga_dbuf_tb.sv */
`timescale 1ns/100ps
`include "vga_dbuf_defines.svh"

module vga_dbuf_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;

  logic       clk;
  logic       reset;
  logic       enable;
  logic [3:0] vga_red;
  logic [3:0] vga_green;
  logic [3:0] vga_blue;
  logic       vga_hsync;
  logic       vga_vsync;
  logic       vga_de;
  int         seed;
  int         low_frames;
  int         error_count;
  int         check_count;
  int         valid_frames;

  vga_dbuf_top u_dut (.*);

  pixel_monitor u_mon (.*);

  bind vga_dbuf_top vga_dbuf_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .frame_end(frame_end),
    .front_sel(front_sel),
    .wr_en    (wr_port.en),
    .rd_en    (rd_port.en),
    .bank0_en (bank0_port.en),
    .bank1_en (bank1_port.en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // called 1 ns after a rising edge, returns at the same offset
  task automatic hold_enable(input logic level, input int frames);
    enable = level;
    repeat (frames * FRAME_CYCLES) @(posedge clk);
    #1;
  endtask

  task automatic finish_run();
    int assert_fails;
    int total_errors;
    assert_fails = u_dut.u_chk.fail_count;
    total_errors = error_count + assert_fails;
    if (valid_frames < 6 + low_frames + 4 - 2) begin
      $display("too few frames with a valid picture were shown: %0d", valid_frames);
      total_errors++;
    end
    $display("checks %0d, monitor errors %0d, assertion failures %0d",
             check_count, error_count, assert_fails);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  initial begin
    reset      = 1'b1;
    enable     = 1'b0;
    seed       = 32'h68e8;
    low_frames = 3 + int'($unsigned($random(seed)) % 3);
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    hold_enable(1'b1, 6);
    hold_enable(1'b0, low_frames);
    hold_enable(1'b1, 4);
    // let the frame on the pins finish
    @(negedge vga_vsync);
    @(posedge clk);
    finish_run();
  end

  initial begin
    #1;
    #((6 + low_frames + 4 + 4) * FRAME_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not reach its end in time");
    $display("TB FAILED");
    $finish;
  end

endmodule

/* all.f */
+incdir+hdl
hdl/vga_dbuf_pkg.sv
hdl/bank_port_if.sv
hdl/buf_swap_ctrl.sv
hdl/pattern_writer.sv
hdl/frame_bank.sv
hdl/bank_router.sv
hdl/scan_out.sv
hdl/vga_dbuf_top.sv
tests/vga_dbuf_chk.sv
tests/pixel_monitor.sv
tests/vga_dbuf_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the VGA double-buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module vga_dbuf_tb -f all.f -o vga_dbuf_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/vga_dbuf_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0
